// File: source/gat_mem_pkg.sv
package gat_mem_pkg;

  // ================================================
  // Sizes
  // ================================================

  // Quantized feature or weight value
  localparam int VALUE_W   = 8;
  // Column index carried by a sparse H entry
  localparam int COL_IDX_W = 11;
  // Word of the new-feature store
  localparam int FEAT_W    = 32;

  // Bank depths
  localparam int H_DEPTH    = 256;
  localparam int WGT_DEPTH  = 64;
  localparam int FEAT_DEPTH = 64;

  // Shared address field sized for the deepest bank
  localparam int ADDR_W = 8;

  // Request queue entries and starting credits per requester
  localparam int CREDIT_DEPTH = 4;

  localparam int NUM_PORTS = 3;

  // ================================================
  // Codes
  // ================================================

  typedef enum logic [1:0] {
    bank_h    = 2'd0,
    bank_wgt  = 2'd1,
    bank_feat = 2'd2
  } bank_e;

  // Also used as the index of a requester in per-port arrays
  typedef enum logic [1:0] {
    port_host  = 2'd0,
    port_conv1 = 2'd1,
    port_conv2 = 2'd2
  } port_e;

  // ================================================
  // Bank words and bus structs
  // ================================================

  typedef struct packed {
    logic [VALUE_W-1:0]   value;
    logic [COL_IDX_W-1:0] col_idx;
  } h_word_t;

  typedef logic [VALUE_W-1:0] wgt_word_t;

  typedef logic [FEAT_W-1:0] feat_word_t;

  // Narrow banks use only the low bits of wdata
  typedef struct packed {
    bank_e             bank;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [FEAT_W-1:0] wdata;
  } mem_req_t;

  // Read data zero-extended from the bank word
  typedef struct packed {
    port_e             port;
    logic [FEAT_W-1:0] rdata;
  } mem_rsp_t;

endpackage

// File: source/bram_bank.sv
module bram_bank
  import gat_mem_pkg::*;
#(
  parameter type word_t = logic [FEAT_W-1:0],
  parameter int  DEPTH  = 256
) (
  input  logic              clk,
  input  logic              en,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  word_t             wdata,
  output word_t             rdata
);

  localparam int IDX_W = $clog2(DEPTH);

  word_t            mem [DEPTH];
  logic [IDX_W-1:0] idx;

  // Shallow banks ignore the upper address bits
  assign idx = addr[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[idx] <= wdata;
      end else begin
        rdata <= mem[idx];
      end
    end
  end

endmodule

// File: source/req_queue.sv
module req_queue
  import gat_mem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid,
  input  mem_req_t req,
  output logic     head_valid,
  output mem_req_t head,
  input  logic     pop,
  output logic     credit
);

  localparam int PTR_W = $clog2(CREDIT_DEPTH);
  localparam int CNT_W = $clog2(CREDIT_DEPTH + 1);

  mem_req_t         entries [CREDIT_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Wrap at the queue depth
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(CREDIT_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign head_valid = (count != '0);
  assign head       = entries[rd_ptr];

  // ================================================
  // Pointers, occupancy and credit return
  // ================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (req_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({req_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit back for every released entry
      credit <= pop;
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (req_valid) begin
      entries[wr_ptr] <= req;
    end
  end

endmodule

// File: source/port_arbiter.sv
module port_arbiter
  import gat_mem_pkg::*;
(
  input  logic                 gat_layer,
  input  logic [NUM_PORTS-1:0] head_valid,
  input  mem_req_t             heads [NUM_PORTS],
  output logic [NUM_PORTS-1:0] pop,
  output logic                 grant_valid,
  output mem_req_t             grant,
  output port_e                grant_port
);

  port_e engine_port;
  logic  host_valid;
  logic  engine_valid;
  port_e win_port;

  // ================================================
  // Fixed priority with the host first
  // ================================================

  // Layer 0 runs conv1, layer 1 runs conv2
  assign engine_port = gat_layer ? port_conv2 : port_conv1;

  assign host_valid   = head_valid[port_host];
  // The idle engine's queue is simply not looked at
  assign engine_valid = head_valid[engine_port];

  always_comb begin
    if (host_valid) begin
      win_port = port_host;
    end else begin
      win_port = engine_port;
    end
  end

  assign grant_valid = host_valid || engine_valid;
  assign grant_port  = win_port;
  assign grant       = heads[win_port];

  // ================================================
  // Pop the winning queue in the grant cycle
  // ================================================

  always_comb begin
    pop = '0;
    if (grant_valid) begin
      pop[win_port] = 1'b1;
    end
  end

endmodule

// File: source/bank_router.sv
module bank_router
  import gat_mem_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              grant_valid,
  input  mem_req_t          grant,
  input  port_e             grant_port,
  // H store
  output logic              h_en,
  output logic              h_we,
  output logic [ADDR_W-1:0] h_addr,
  output h_word_t           h_wdata,
  input  h_word_t           h_rdata,
  // Weight store
  output logic              wgt_en,
  output logic              wgt_we,
  output logic [ADDR_W-1:0] wgt_addr,
  output wgt_word_t         wgt_wdata,
  input  wgt_word_t         wgt_rdata,
  // New-feature store
  output logic              feat_en,
  output logic              feat_we,
  output logic [ADDR_W-1:0] feat_addr,
  output feat_word_t        feat_wdata,
  input  feat_word_t        feat_rdata,
  output logic              rsp_valid,
  output mem_rsp_t          rsp
);

  localparam int H_W = $bits(h_word_t);

  port_e rd_port_q;
  bank_e rd_bank_q;

  // ================================================
  // Request decode
  // ================================================

  assign h_en    = grant_valid && (grant.bank == bank_h);
  assign wgt_en  = grant_valid && (grant.bank == bank_wgt);
  assign feat_en = grant_valid && (grant.bank == bank_feat);

  assign h_we    = grant.we;
  assign wgt_we  = grant.we;
  assign feat_we = grant.we;

  assign h_addr    = grant.addr;
  assign wgt_addr  = grant.addr;
  assign feat_addr = grant.addr;

  // Truncate the shared write data to each bank's word
  assign h_wdata    = h_word_t'(grant.wdata[H_W-1:0]);
  assign wgt_wdata  = grant.wdata[VALUE_W-1:0];
  assign feat_wdata = grant.wdata;

  // ================================================
  // Read tag one cycle behind the bank access
  // ================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= grant_valid && !grant.we;
    end
  end

  always_ff @(posedge clk) begin
    rd_port_q <= grant_port;
    rd_bank_q <= grant.bank;
  end

  assign rsp.port = rd_port_q;

  always_comb begin
    case (rd_bank_q)
      bank_h:    rsp.rdata = {{(FEAT_W - H_W){1'b0}}, h_rdata};
      bank_wgt:  rsp.rdata = {{(FEAT_W - VALUE_W){1'b0}}, wgt_rdata};
      bank_feat: rsp.rdata = feat_rdata;
      default:   rsp.rdata = '0;
    endcase
  end

endmodule

// File: source/gat_mem_ctrl.sv
module gat_mem_ctrl
  import gat_mem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     gat_layer,
  // Host loader
  input  logic     host_req_valid,
  input  mem_req_t host_req,
  output logic     host_credit,
  // Layer-1 engine
  input  logic     conv1_req_valid,
  input  mem_req_t conv1_req,
  output logic     conv1_credit,
  // Layer-2 engine
  input  logic     conv2_req_valid,
  input  mem_req_t conv2_req,
  output logic     conv2_credit,
  output logic     rsp_valid,
  output mem_rsp_t rsp
);

  logic [NUM_PORTS-1:0] head_valid;
  mem_req_t             heads [NUM_PORTS];
  logic [NUM_PORTS-1:0] pop;

  logic     grant_valid;
  mem_req_t grant;
  port_e    grant_port;

  logic              h_en, h_we;
  logic [ADDR_W-1:0] h_addr;
  h_word_t           h_wdata, h_rdata;

  logic              wgt_en, wgt_we;
  logic [ADDR_W-1:0] wgt_addr;
  wgt_word_t         wgt_wdata, wgt_rdata;

  logic              feat_en, feat_we;
  logic [ADDR_W-1:0] feat_addr;
  feat_word_t        feat_wdata, feat_rdata;

  // ================================================
  // Request queues
  // ================================================

  req_queue u_host_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (host_req_valid),
    .req        (host_req),
    .head_valid (head_valid[port_host]),
    .head       (heads[port_host]),
    .pop        (pop[port_host]),
    .credit     (host_credit)
  );

  req_queue u_conv1_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (conv1_req_valid),
    .req        (conv1_req),
    .head_valid (head_valid[port_conv1]),
    .head       (heads[port_conv1]),
    .pop        (pop[port_conv1]),
    .credit     (conv1_credit)
  );

  req_queue u_conv2_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (conv2_req_valid),
    .req        (conv2_req),
    .head_valid (head_valid[port_conv2]),
    .head       (heads[port_conv2]),
    .pop        (pop[port_conv2]),
    .credit     (conv2_credit)
  );

  // ================================================
  // Arbitration and routing
  // ================================================

  port_arbiter u_port_arbiter (
    .gat_layer   (gat_layer),
    .head_valid  (head_valid),
    .heads       (heads),
    .pop         (pop),
    .grant_valid (grant_valid),
    .grant       (grant),
    .grant_port  (grant_port)
  );

  bank_router u_bank_router (
    .clk         (clk),
    .rst_n       (rst_n),
    .grant_valid (grant_valid),
    .grant       (grant),
    .grant_port  (grant_port),
    .h_en        (h_en),
    .h_we        (h_we),
    .h_addr      (h_addr),
    .h_wdata     (h_wdata),
    .h_rdata     (h_rdata),
    .wgt_en      (wgt_en),
    .wgt_we      (wgt_we),
    .wgt_addr    (wgt_addr),
    .wgt_wdata   (wgt_wdata),
    .wgt_rdata   (wgt_rdata),
    .feat_en     (feat_en),
    .feat_we     (feat_we),
    .feat_addr   (feat_addr),
    .feat_wdata  (feat_wdata),
    .feat_rdata  (feat_rdata),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp)
  );

  // ================================================
  // Banks
  // ================================================

  // Sparse H entries of value and column index
  bram_bank #(
    .word_t (h_word_t),
    .DEPTH  (H_DEPTH)
  ) u_h_bram (
    .clk   (clk),
    .en    (h_en),
    .we    (h_we),
    .addr  (h_addr),
    .wdata (h_wdata),
    .rdata (h_rdata)
  );

  bram_bank #(
    .word_t (wgt_word_t),
    .DEPTH  (WGT_DEPTH)
  ) u_wgt_bram (
    .clk   (clk),
    .en    (wgt_en),
    .we    (wgt_we),
    .addr  (wgt_addr),
    .wdata (wgt_wdata),
    .rdata (wgt_rdata)
  );

  bram_bank #(
    .word_t (feat_word_t),
    .DEPTH  (FEAT_DEPTH)
  ) u_feat_bram (
    .clk   (clk),
    .en    (feat_en),
    .we    (feat_we),
    .addr  (feat_addr),
    .wdata (feat_wdata),
    .rdata (feat_rdata)
  );

endmodule

// File: test/tb_gat_mem_ctrl.sv
module tb_gat_mem_ctrl
  import gat_mem_pkg::*;
();

  typedef struct {
    string             name;
    logic              req;
    port_e             port;
    bank_e             bank;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [FEAT_W-1:0] data;
    logic              gat_layer;
    logic              pair;
    logic              quiet;
    logic              drain;
  } step_t;

  localparam int TIMEOUT = 100;

  logic     clk, rst_n, gat_layer, rsp_valid;
  logic     host_req_valid, conv1_req_valid, conv2_req_valid;
  mem_req_t host_req, conv1_req, conv2_req;
  logic     host_credit, conv1_credit, conv2_credit;
  mem_rsp_t rsp;

  integer     seed = 32'h6713d80e;
  step_t      steps [$];
  h_word_t    h_model [H_DEPTH];
  wgt_word_t  wgt_model [WGT_DEPTH];
  feat_word_t feat_model [FEAT_DEPTH];
  int         credits [NUM_PORTS];
  int         rsp_seen [NUM_PORTS];
  int         rsp_cycle [NUM_PORTS];
  int         cycle;
  mem_rsp_t   exp_q [NUM_PORTS][$];
  string      name_q [NUM_PORTS][$];

  gat_mem_ctrl gat_mem_ctrl_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_rsp(input string name, input mem_rsp_t exp, input mem_rsp_t act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: expected port %0d data %h, actual port %0d data %h",
                          name, exp.port, exp.rdata, act.port, act.rdata));
    end
  endtask

  task automatic check_credit(input string name, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("CHECK FAILED %s: expected credits %0d, actual credits %0d",
                          name, exp, act));
    end
  endtask

  task automatic check_all_credits(input string name, input int exp);
    check_credit(name, exp, credits[port_host]);
    check_credit(name, exp, credits[port_conv1]);
    check_credit(name, exp, credits[port_conv2]);
  endtask

  // ==================================================
  // Reference model
  // ==================================================

  task automatic model_write(input bank_e b, input int a, input logic [FEAT_W-1:0] d);
    case (b)
      bank_h:   h_model[a] = d[$bits(h_word_t)-1:0];
      bank_wgt: wgt_model[a] = d[VALUE_W-1:0];
      default:  feat_model[a] = d;
    endcase
  endtask

  // Bank word zero-extended to the response width
  function automatic logic [FEAT_W-1:0] model_read(input bank_e b, input int a);
    logic [FEAT_W-1:0] v;
    v = '0;
    case (b)
      bank_h:   v[$bits(h_word_t)-1:0] = h_model[a];
      bank_wgt: v[VALUE_W-1:0] = wgt_model[a];
      default:  v = feat_model[a];
    endcase
    return v;
  endfunction

  function automatic logic all_done();
    return exp_q[port_host].size() == 0 && exp_q[port_conv1].size() == 0 &&
           exp_q[port_conv2].size() == 0 && credits[port_host] >= CREDIT_DEPTH &&
           credits[port_conv1] >= CREDIT_DEPTH && credits[port_conv2] >= CREDIT_DEPTH;
  endfunction

  // Credits and responses sampled mid-cycle
  always @(negedge clk) begin
    cycle++;
    if (rst_n) begin
      if (host_credit) credits[port_host]++;
      if (conv1_credit) credits[port_conv1]++;
      if (conv2_credit) credits[port_conv2]++;
      if (rsp_valid) begin
        if (rsp.port > port_conv2 || exp_q[rsp.port].size() == 0) begin
          abort_run("A read response arrived with no read outstanding for that requester");
        end else begin
          check_rsp(name_q[rsp.port].pop_front(), exp_q[rsp.port].pop_front(), rsp);
          rsp_seen[rsp.port]++;
          rsp_cycle[rsp.port] = cycle;
        end
      end
    end
  end

  // ==================================================
  // Stimulus table
  // ==================================================

  task automatic add_step(input string name, input int req, input port_e port, input bank_e bank,
                          input int we, input int addr, input int gl, input int pair,
                          input int quiet, input int drain);
    step_t s;
    s.name      = name;
    s.req       = (req != 0);
    s.port      = port;
    s.bank      = bank;
    s.we        = (we != 0);
    s.addr      = ADDR_W'(addr);
    s.data      = (we != 0) ? $random(seed) : '0;
    s.gat_layer = (gl != 0);
    s.pair      = (pair != 0);
    s.quiet     = (quiet != 0);
    s.drain     = (drain != 0);
    steps.push_back(s);
  endtask

  task automatic build_steps();
    add_step("host_wr_h",      1, port_host,  bank_h,    1, 'hc3, 0, 0, 0, 0);
    add_step("host_wr_wgt",    1, port_host,  bank_wgt,  1, 'h2a, 0, 0, 0, 0);
    add_step("host_wr_feat",   1, port_host,  bank_feat, 1, 'h11, 0, 0, 0, 1);
    add_step("host_rd_h",      1, port_host,  bank_h,    0, 'hc3, 0, 0, 0, 0);
    add_step("host_rd_wgt",    1, port_host,  bank_wgt,  0, 'h2a, 0, 0, 0, 0);
    add_step("host_rd_feat",   1, port_host,  bank_feat, 0, 'h11, 0, 0, 0, 1);
    add_step("conv1_rd0",      1, port_conv1, bank_h,    0, 'hc3, 0, 0, 0, 0);
    add_step("conv1_rd1",      1, port_conv1, bank_wgt,  0, 'h2a, 0, 0, 0, 0);
    add_step("conv1_rd2",      1, port_conv1, bank_feat, 0, 'h11, 0, 0, 0, 0);
    add_step("conv1_rd3",      1, port_conv1, bank_h,    0, 'hc3, 0, 0, 0, 1);
    // conv2 is parked until layer 2 is selected
    add_step("conv2_rd0",      1, port_conv2, bank_feat, 0, 'h11, 0, 0, 0, 0);
    add_step("conv2_rd1",      1, port_conv2, bank_h,    0, 'hc3, 0, 0, 0, 0);
    add_step("conv2_rd2",      1, port_conv2, bank_wgt,  0, 'h2a, 0, 0, 0, 0);
    add_step("conv2_rd3",      1, port_conv2, bank_feat, 0, 'h11, 0, 0, 1, 0);
    add_step("layer2_on",      0, port_conv2, bank_h,    0, 'h00, 1, 0, 0, 1);
    add_step("mix_host_rd",    1, port_host,  bank_h,    0, 'hc3, 1, 1, 0, 0);
    add_step("mix_conv2_rd",   1, port_conv2, bank_feat, 0, 'h11, 1, 0, 0, 1);
    add_step("conv2_wr_feat",  1, port_conv2, bank_feat, 1, 'h30, 1, 0, 0, 1);
    add_step("host_rd_shared", 1, port_host,  bank_feat, 0, 'h30, 1, 0, 0, 1);
  endtask

  task automatic clear_valids();
    host_req_valid  = 1'b0;
    conv1_req_valid = 1'b0;
    conv2_req_valid = 1'b0;
  endtask

  task automatic wait_credit(input port_e p);
    int t;
    t = 0;
    while (credits[p] == 0) begin
      @(posedge clk);
      #1;
      t++;
      if (t > TIMEOUT) abort_run("A requester never got a credit back");
    end
  endtask

  task automatic drain(input string name);
    int t;
    t = 0;
    while (!all_done()) begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) abort_run($sformatf("Responses or credits missing after step %s", name));
    end
    check_all_credits(name, CREDIT_DEPTH);
  endtask

  task automatic drive_step(input step_t s);
    mem_req_t r;
    mem_rsp_t e;
    r = '{bank: s.bank, we: s.we, addr: s.addr, wdata: s.data};
    if (s.we) begin
      model_write(s.bank, int'(s.addr), s.data);
    end else begin
      e.port  = s.port;
      e.rdata = model_read(s.bank, int'(s.addr));
      exp_q[s.port].push_back(e);
      name_q[s.port].push_back(s.name);
    end
    credits[s.port]--;
    case (s.port)
      port_host: begin
        host_req_valid = 1'b1;
        host_req       = r;
      end
      port_conv1: begin
        conv1_req_valid = 1'b1;
        conv1_req       = r;
      end
      default: begin
        conv2_req_valid = 1'b1;
        conv2_req       = r;
      end
    endcase
  endtask

  // ==================================================
  // Main sequence
  // ==================================================

  initial begin
    step_t s;
    int    seen;
    rst_n     = 1'b0;
    gat_layer = 1'b0;
    host_req  = '0;
    conv1_req = '0;
    conv2_req = '0;
    clear_valids();
    credits   = '{default: CREDIT_DEPTH};
    rsp_seen  = '{default: 0};
    rsp_cycle = '{default: 0};
    cycle     = 0;
    build_steps();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Idle memory must stay silent
    repeat (10) @(posedge clk);
    check_all_credits("idle_after_reset", CREDIT_DEPTH);
    for (int i = 0; i < steps.size(); i++) begin
      s = steps[i];
      @(posedge clk);
      #1;
      clear_valids();
      gat_layer = s.gat_layer;
      if (s.req) wait_credit(s.port);
      if (s.pair) wait_credit(steps[i+1].port);
      if (s.req) drive_step(s);
      if (s.pair) begin
        i++;
        drive_step(steps[i]);
      end
      if (steps[i].quiet || steps[i].drain) begin
        @(posedge clk);
        #1;
        clear_valids();
      end
      if (steps[i].quiet) begin
        seen = rsp_seen[steps[i].port];
        repeat (20) @(posedge clk);
        check_credit(steps[i].name, 0, credits[steps[i].port]);
        if (rsp_seen[steps[i].port] != seen) abort_run("A parked engine got a read response");
      end
      if (steps[i].drain) drain(steps[i].name);
      if (s.pair && rsp_cycle[port_host] > rsp_cycle[steps[i].port]) begin
        abort_run($sformatf("Engine response came before the host response in %s", s.name));
      end
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: vlog.f
source/gat_mem_pkg.sv
source/bram_bank.sv
source/req_queue.sv
source/port_arbiter.sv
source/bank_router.sv
source/gat_mem_ctrl.sv
test/tb_gat_mem_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f vlog.f --top-module tb_gat_mem_ctrl

status=0
./obj_dir/Vtb_gat_mem_ctrl > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
  exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1
